//--- build.f
logic/snake_pkg.sv
logic/steer_stage.sv
logic/body_stage.sv
logic/score_stage.sv
logic/matrix_scan.sv
logic/snake_top.sv
verification/snake_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS ?= --timing
TOP ?= snake_tb
FILELIST ?= build.f
BUILD_DIR ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TESTS PASSED$$"

clean:
	rm -rf $(BUILD_DIR)

//--- verification/snake_tb.sv
`default_nettype none

module snake_tb;

	localparam int side = snake_pkg::grid_size;
	localparam int wrap_rows = 8;
	localparam int loss_rows = 21;
	localparam int greedy_limit = 150;
	localparam int cycle_limit = 10 * (wrap_rows + loss_rows + greedy_limit) + 200;

	typedef struct packed {
		snake_pkg::dir_t dir;
		logic [5:0] head;
	} move_row_t;

	logic clk;
	logic reset;
	logic move_valid;
	snake_pkg::dir_t move_dir;
	wire move_ready;
	wire snake_pkg::game_status_t status;
	wire [7:0] scan_row;
	wire [7:0] row_red;
	wire [7:0] row_green;

	// reference model with the head at m_body[0]
	int m_body[$];
	int m_apple;
	int m_score;
	snake_pkg::dir_t m_dir;
	snake_pkg::game_state_t m_state;
	int seed;
	int cycles = 0;

	// wraps and reversals first, then a path that grows the snake and bites the body
	move_row_t move_table [29] = '{
		'{snake_pkg::up, 6'd8}, '{snake_pkg::left, 6'd15}, '{snake_pkg::right, 6'd14},
		'{snake_pkg::up, 6'd6}, '{snake_pkg::up, 6'd62}, '{snake_pkg::right, 6'd63},
		'{snake_pkg::right, 6'd56}, '{snake_pkg::down, 6'd0},
		'{snake_pkg::down, 6'd8}, '{snake_pkg::down, 6'd16}, '{snake_pkg::down, 6'd24},
		'{snake_pkg::right, 6'd25}, '{snake_pkg::right, 6'd26}, '{snake_pkg::right, 6'd27},
		'{snake_pkg::right, 6'd28}, '{snake_pkg::up, 6'd20}, '{snake_pkg::up, 6'd12},
		'{snake_pkg::up, 6'd4}, '{snake_pkg::left, 6'd3}, '{snake_pkg::up, 6'd59},
		'{snake_pkg::up, 6'd51}, '{snake_pkg::up, 6'd43}, '{snake_pkg::left, 6'd42},
		'{snake_pkg::up, 6'd34}, '{snake_pkg::up, 6'd26}, '{snake_pkg::up, 6'd18},
		'{snake_pkg::left, 6'd17}, '{snake_pkg::down, 6'd25}, '{snake_pkg::right, 6'd26}
	};

	snake_top u_dut (
		.clk(clk),
		.reset(reset),
		.move_valid(move_valid),
		.move_dir(move_dir),
		.move_ready(move_ready),
		.status(status),
		.scan_row(scan_row),
		.row_red(row_red),
		.row_green(row_green)
	);

	function automatic snake_pkg::dir_t opposite(input snake_pkg::dir_t d);
		case (d)
			snake_pkg::up: return snake_pkg::down;
			snake_pkg::down: return snake_pkg::up;
			snake_pkg::left: return snake_pkg::right;
			default: return snake_pkg::left;
		endcase
	endfunction

	// one cell over, wrapping round the edges
	function automatic int neighbour(input int pos, input snake_pkg::dir_t d);
		int r;
		int c;
		r = pos / side;
		c = pos % side;
		case (d)
			snake_pkg::up: r = (r + side - 1) % side;
			snake_pkg::down: r = (r + 1) % side;
			snake_pkg::left: c = (c + side - 1) % side;
			default: c = (c + 1) % side;
		endcase
		return r * side + c;
	endfunction

	function automatic snake_pkg::occupancy_t model_occupancy();
		snake_pkg::occupancy_t occ;
		occ = '0;
		foreach (m_body[i]) begin
			occ[6'(m_body[i])] = 1'b1;
		end
		return occ;
	endfunction

	function automatic snake_pkg::game_status_t model_status();
		snake_pkg::game_status_t s;
		s.state = m_state;
		s.score = {4'(m_score / 100), 4'(m_score / 10 % 10), 4'(m_score % 10)};
		s.head.index = 6'(m_body[0]);
		s.apple.index = 6'(m_apple);
		s.length = 7'(m_body.size());
		return s;
	endfunction

	task automatic model_step(input snake_pkg::dir_t req);
		int head;
		logic ate;
		snake_pkg::occupancy_t occ;
		if (req != opposite(m_dir)) begin
			m_dir = req;
		end
		head = neighbour(m_body[0], m_dir);
		ate = (head == m_apple);
		// tail moves away before the head lands
		if (!ate) begin
			void'(m_body.pop_back());
			occ = model_occupancy();
			if (occ[6'(head)]) begin
				m_state = snake_pkg::lost;
			end
		end
		m_body.push_front(head);
		if (ate) begin
			m_score++;
			if (m_body.size() == snake_pkg::win_length) begin
				m_state = snake_pkg::won;
			end else begin
				occ = model_occupancy();
				m_apple = (m_apple + snake_pkg::apple_stride) % snake_pkg::cell_count;
				while (occ[6'(m_apple)]) begin
					m_apple = (m_apple + snake_pkg::apple_stride) % snake_pkg::cell_count;
				end
			end
		end
	endtask

	task automatic fail_run();
		$display("TESTS FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic compare_field(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_status(input string name, input snake_pkg::game_status_t exp);
		compare_field({name, " state"}, 64'(exp.state), 64'(status.state));
		compare_field({name, " score"}, 64'(exp.score), 64'(status.score));
		compare_field({name, " head"}, 64'(exp.head), 64'(status.head));
		compare_field({name, " apple"}, 64'(exp.apple), 64'(status.apple));
		compare_field({name, " length"}, 64'(exp.length), 64'(status.length));
	endtask

	task automatic check_row(input string name, input logic [7:0] exp_row,
			input logic [7:0] exp_red, input logic [7:0] exp_green);
		compare_field({name, " select"}, 64'(exp_row), 64'(scan_row));
		compare_field({name, " red"}, 64'(exp_red), 64'(row_red));
		compare_field({name, " green"}, 64'(exp_green), 64'(row_green));
	endtask

	task automatic check_ready(input string name, input logic exp);
		compare_field(name, 64'(exp), 64'(move_ready));
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b0;
		move_valid <= 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b1;
		m_body.delete();
		m_body.push_back(0);
		m_dir = snake_pkg::down;
		m_apple = snake_pkg::start_apple;
		m_score = 0;
		m_state = snake_pkg::playing;
		@(negedge clk);
	endtask

	// hold the request until taken, then let the three stages run
	task automatic apply_move(input snake_pkg::dir_t d);
		@(negedge clk);
		while (!move_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		move_valid <= 1'b1;
		move_dir <= d;
		@(posedge clk);
		move_valid <= 1'b0;
		model_step(d);
		repeat (3) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic run_table(input int first, input int count);
		snake_pkg::game_status_t exp;
		for (int i = first; i < first + count; i++) begin
			apply_move(move_table[i].dir);
			exp = model_status();
			exp.head.index = move_table[i].head;
			check_status($sformatf("table row %0d", i), exp);
			check_ready($sformatf("table row %0d ready", i), m_state == snake_pkg::playing);
		end
	endtask

	// head for the apple, skipping reversals and body cells
	task automatic run_greedy();
		int best;
		int cost;
		int next_pos;
		int dr;
		int dc;
		snake_pkg::dir_t d;
		snake_pkg::dir_t choice;
		snake_pkg::occupancy_t occ;
		for (int n = 0; n < greedy_limit && m_state == snake_pkg::playing; n++) begin
			best = 1000;
			choice = m_dir;
			occ = model_occupancy();
			occ[6'(m_body[$])] = 1'b0;
			for (int k = 0; k < 4; k++) begin
				d = snake_pkg::dir_t'(k);
				next_pos = neighbour(m_body[0], d);
				dr = (next_pos / side - m_apple / side + side) % side;
				dc = (next_pos % side - m_apple % side + side) % side;
				cost = 4 * ((dr > side / 2 ? side - dr : dr) + (dc > side / 2 ? side - dc : dc));
				// low bits only break ties
				cost = cost + ($random(seed) & 3);
				if (d != opposite(m_dir) && !occ[6'(next_pos)] && cost < best) begin
					best = cost;
					choice = d;
				end
			end
			apply_move(choice);
			check_status($sformatf("greedy move %0d", n), model_status());
			check_ready($sformatf("greedy move %0d ready", n), m_state == snake_pkg::playing);
		end
		if (m_state != snake_pkg::won) begin
			$display("greedy phase ended without winning the game");
			fail_run();
		end
	endtask

	// eight rows in a row, starting wherever the counter happens to be
	task automatic check_scan(input string name);
		snake_pkg::occupancy_t occ;
		logic [7:0] red;
		logic [7:0] green;
		int row;
		int head;
		occ = model_occupancy();
		head = m_body[0];
		@(negedge clk);
		row = 0;
		while (row < side && scan_row != 8'(1 << row)) begin
			row++;
		end
		if (row == side) begin
			$display("scan row select %b is not one-hot", scan_row);
			fail_run();
		end
		repeat (side) begin
			red = 8'h00;
			for (int c = 0; c < side; c++) begin
				green[3'(side - 1 - c)] = occ[6'(row * side + c)];
			end
			if (head / side == row) red[3'(side - 1 - head % side)] = 1'b1;
			if (m_apple / side == row) red[3'(side - 1 - m_apple % side)] = 1'b1;
			check_row($sformatf("%s row %0d", name, row), 8'(1 << row), red, green);
			row = (row + 1) % side;
			@(negedge clk);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run was still going after %0d cycles", cycles);
			fail_run();
		end
	end

	initial begin
		seed = 32'h15d2;
		reset = 1'b0;
		move_valid = 1'b0;
		move_dir = snake_pkg::up;
		apply_reset();
		check_status("after reset", model_status());
		check_ready("ready after reset", 1'b1);
		check_scan("scan after reset");
		run_table(0, wrap_rows);
		check_scan("scan after wraps");
		run_greedy();
		apply_reset();
		run_table(wrap_rows, loss_rows);
		// a held request must not restart a lost game
		@(posedge clk);
		move_valid <= 1'b1;
		repeat (20) begin
			@(negedge clk);
			check_ready("ready held low after loss", 1'b0);
		end
		check_status("status after loss", model_status());
		@(posedge clk);
		move_valid <= 1'b0;
		check_scan("scan after loss");
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/snake_top.sv
`default_nettype none

module snake_top (
	input wire clk,
	input wire reset,
	input wire move_valid,
	input wire snake_pkg::dir_t move_dir,
	output wire move_ready,
	output wire snake_pkg::game_status_t status,
	output wire [7:0] scan_row,
	output wire [7:0] row_red,
	output wire [7:0] row_green
);

	wire step_done;
	wire playing;
	wire head_valid;
	wire snake_pkg::step_t step;
	wire result_valid;
	wire snake_pkg::body_result_t result;
	wire snake_pkg::cell_t apple;

	steer_stage u_steer (
		.clk(clk),
		.reset(reset),
		.move_valid(move_valid),
		.move_dir(move_dir),
		.move_ready(move_ready),
		.step_done(step_done),
		.playing(playing),
		.head_valid(head_valid),
		.step(step)
	);

	body_stage u_body (
		.clk(clk),
		.reset(reset),
		.head_valid(head_valid),
		.step(step),
		.apple(apple),
		.result_valid(result_valid),
		.result(result)
	);

	score_stage u_score (
		.clk(clk),
		.reset(reset),
		.result_valid(result_valid),
		.result(result),
		.step_done(step_done),
		.playing(playing),
		.apple(apple),
		.status(status)
	);

	// head and occupancy come from the same register, so they stay in step
	matrix_scan u_scan (
		.clk(clk),
		.reset(reset),
		.occupancy(result.occupancy),
		.head(result.head),
		.apple(apple),
		.scan_row(scan_row),
		.row_red(row_red),
		.row_green(row_green)
	);

endmodule

`default_nettype wire

//--- logic/matrix_scan.sv
`default_nettype none

module matrix_scan (
	input wire clk,
	input wire reset,
	input wire snake_pkg::occupancy_t occupancy,
	input wire snake_pkg::cell_t head,
	input wire snake_pkg::cell_t apple,
	output logic [7:0] scan_row,
	output logic [7:0] row_red,
	output logic [7:0] row_green
);

	logic [2:0] row;
	logic [7:0] green;
	logic [7:0] red;

	// column 0 lands on the msb
	always_comb begin
		for (int c = 0; c < snake_pkg::grid_size; c++) begin
			green[snake_pkg::grid_size - 1 - c] = occupancy[{row, 3'(c)}];
		end
		red = 8'h00;
		if (head.rc.row == row) begin
			red = red | (8'h80 >> head.rc.col);
		end
		if (apple.rc.row == row) begin
			red = red | (8'h80 >> apple.rc.col);
		end
	end

	// outputs trail the row counter by one clock
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			row <= 3'd0;
			scan_row <= 8'h00;
			row_red <= 8'h00;
			row_green <= 8'h00;
		end else begin
			row <= row + 3'd1;
			scan_row <= 8'h01 << row;
			row_red <= red;
			row_green <= green;
		end
	end

endmodule

`default_nettype wire

//--- logic/score_stage.sv
`default_nettype none

module score_stage (
	input wire clk,
	input wire reset,
	input wire result_valid,
	input wire snake_pkg::body_result_t result,
	output logic step_done,
	output logic playing,
	output snake_pkg::cell_t apple,
	output snake_pkg::game_status_t status
);

	snake_pkg::game_status_t next_status;
	snake_pkg::cell_t next_apple;
	logic [5:0] candidate;
	logic found;

	// decimal increment over three digits, 999 rolls to 000
	function automatic logic [11:0] bcd_inc(input logic [11:0] value);
		logic [11:0] sum;
		logic carry;
		sum = value;
		carry = 1'b1;
		for (int d = 0; d < 3; d++) begin
			if (carry) begin
				if (sum[d*4 +: 4] == 4'd9) begin
					sum[d*4 +: 4] = 4'd0;
				end else begin
					sum[d*4 +: 4] = sum[d*4 +: 4] + 4'd1;
					carry = 1'b0;
				end
			end
		end
		return sum;
	endfunction

	// first free cell along the stride, starting one stride past the apple
	always_comb begin
		next_apple = status.apple;
		found = 1'b0;
		candidate = status.apple.index + 6'(snake_pkg::apple_stride);
		for (int i = 0; i < snake_pkg::cell_count; i++) begin
			if (!found && !result.occupancy[candidate]) begin
				found = 1'b1;
				next_apple.index = candidate;
			end
			candidate = candidate + 6'(snake_pkg::apple_stride);
		end
	end

	always_comb begin
		next_status = status;
		if (result_valid) begin
			next_status.head = result.head;
			next_status.length = result.length;
			if (result.collided) begin
				next_status.state = snake_pkg::lost;
			end else if (result.ate) begin
				next_status.score = bcd_inc(status.score);
				if (result.length == 7'(snake_pkg::win_length)) begin
					next_status.state = snake_pkg::won;
				end else begin
					next_status.apple = next_apple;
				end
			end
		end
	end

	// steer reopens on the same edge that status updates
	assign step_done = result_valid;
	assign playing = (next_status.state == snake_pkg::playing);
	assign apple = status.apple;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			status.state <= snake_pkg::playing;
			status.score <= 12'h000;
			status.head <= '0;
			status.apple.index <= 6'(snake_pkg::start_apple);
			status.length <= 7'd1;
		end else begin
			status <= next_status;
		end
	end

endmodule

`default_nettype wire

//--- logic/body_stage.sv
`default_nettype none

module body_stage (
	input wire clk,
	input wire reset,
	input wire head_valid,
	input wire snake_pkg::step_t step,
	input wire snake_pkg::cell_t apple,
	output logic result_valid,
	output snake_pkg::body_result_t result
);

	// head at body[0] and tail at body[length-1]
	snake_pkg::cell_t body [snake_pkg::cell_count];
	logic [5:0] tail_pos;
	snake_pkg::cell_t tail;
	logic ate;
	logic collided;
	snake_pkg::occupancy_t freed;

	// result also holds the live length and occupancy
	assign tail_pos = 6'(result.length - 7'd1);
	assign tail = body[tail_pos];
	assign ate = (step.head == apple);

	// tail leaves before the head arrives, unless the snake grows
	always_comb begin
		freed = result.occupancy;
		if (!ate) begin
			freed[tail.index] = 1'b0;
		end
	end

	assign collided = !ate && freed[step.head.index];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			result_valid <= 1'b0;
			result.head <= '0;
			result.collided <= 1'b0;
			result.ate <= 1'b0;
			result.length <= 7'd1;
			result.occupancy <= snake_pkg::occupancy_t'(1);
			for (int i = 0; i < snake_pkg::cell_count; i++) begin
				body[i] <= '0;
			end
		end else begin
			result_valid <= head_valid;
			if (head_valid) begin
				result.head <= step.head;
				result.collided <= collided;
				result.ate <= ate;
				if (ate) begin
					result.length <= result.length + 7'd1;
				end
				result.occupancy <= freed | (snake_pkg::occupancy_t'(1) << step.head.index);
				// shift the list and keep the old tail on growth
				body[0] <= step.head;
				for (int i = 1; i < snake_pkg::cell_count; i++) begin
					body[i] <= body[i-1];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/steer_stage.sv
`default_nettype none

module steer_stage (
	input wire clk,
	input wire reset,
	input wire move_valid,
	input wire snake_pkg::dir_t move_dir,
	output logic move_ready,
	input wire step_done,
	input wire playing,
	output logic head_valid,
	output snake_pkg::step_t step
);

	logic pending;
	snake_pkg::dir_t req_dir;
	snake_pkg::dir_t dir;
	snake_pkg::dir_t new_dir;
	snake_pkg::cell_t next_head;

	// opposite directions differ only in bit 0
	always_comb begin
		new_dir = dir;
		if ((req_dir ^ dir) != 2'b01) begin
			new_dir = req_dir;
		end
	end

	// 3-bit row/col arithmetic wraps at the edges by itself
	always_comb begin
		next_head = step.head;
		case (new_dir)
			snake_pkg::up: next_head.rc.row = step.head.rc.row - 3'd1;
			snake_pkg::down: next_head.rc.row = step.head.rc.row + 3'd1;
			snake_pkg::left: next_head.rc.col = step.head.rc.col - 3'd1;
			snake_pkg::right: next_head.rc.col = step.head.rc.col + 3'd1;
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			move_ready <= 1'b1;
			pending <= 1'b0;
			req_dir <= snake_pkg::down;
			dir <= snake_pkg::down;
			head_valid <= 1'b0;
			step <= '0;
		end else begin
			head_valid <= pending;
			if (move_valid && move_ready) begin
				move_ready <= 1'b0;
				pending <= 1'b1;
				req_dir <= move_dir;
			end else if (step_done && playing) begin
				move_ready <= 1'b1;
			end
			// step one cycle after acceptance
			if (pending) begin
				pending <= 1'b0;
				dir <= new_dir;
				step.head <= next_head;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/snake_pkg.sv
`default_nettype none

package snake_pkg;

	// matrix geometry
	localparam int grid_size = 8;
	localparam int cell_count = grid_size * grid_size;

	// game rules
	localparam int win_length = 8;
	// odd stride, so the search reaches every cell
	localparam int apple_stride = 39;
	// row 3, column 4
	localparam int start_apple = 28;

	typedef struct packed {
		logic [2:0] row;
		logic [2:0] col;
	} cell_rc_t;

	// same six bits, read as index or as row/col
	typedef union packed {
		logic [5:0] index;
		cell_rc_t rc;
	} cell_t;

	typedef enum logic [1:0] {
		up = 2'd0,
		down = 2'd1,
		left = 2'd2,
		right = 2'd3
	} dir_t;

	typedef enum logic [1:0] {
		playing = 2'd0,
		lost = 2'd1,
		won = 2'd2
	} game_state_t;

	// one bit per cell index
	typedef logic [cell_count-1:0] occupancy_t;

	typedef struct packed {
		cell_t head;
	} step_t;

	typedef struct packed {
		cell_t head;
		logic collided;
		logic ate;
		logic [6:0] length;
		occupancy_t occupancy;
	} body_result_t;

	// score is three bcd digits
	typedef struct packed {
		game_state_t state;
		logic [11:0] score;
		cell_t head;
		cell_t apple;
		logic [6:0] length;
	} game_status_t;

endpackage

`default_nettype wire
